// ==== verilog/fdc_settings.svh ====
`ifndef FDC_SETTINGS_SVH
`define FDC_SETTINGS_SVH

// =========================================================================
// timer reloads, all in clk_sys cycles
// =========================================================================
`define FDC_SEEK_CYCLES      1023   // settle before sector search
`define FDC_BUSY_CYCLES      4000   // type I and refused commands
`define FDC_WATCHDOG_CYCLES  4096   // host must take a byte within this
`define FDC_INDEX_PERIOD     35000
`define FDC_INDEX_WIDTH      100
`define FDC_BYTE_DELAY       15     // before each drq

// =========================================================================
// widths and counts
// =========================================================================
`define FDC_IMAGE_AW         20
`define FDC_REG_COUNT        4
`define FDC_TIMER_W          12     // holds the largest engine reload
`define FDC_INDEX_W          16
`define FDC_WATCHDOG_W       13

`endif

// ==== verilog/fdc_bus_pkg.sv ====
`include "fdc_settings.svh"

package fdc_bus_pkg;

	typedef logic [7:0] byte_t;

	// host register map, status and command share address 0
	typedef enum logic [$clog2(`FDC_REG_COUNT)-1:0] {
		A_CMD_STATUS = 2'd0,
		A_TRACK      = 2'd1,
		A_SECTOR     = 2'd2,
		A_DATA       = 2'd3
	} reg_addr_t;

	// top nibble of a command byte
	typedef enum logic [3:0] {
		C_RESTORE     = 4'h0,
		C_SEEK        = 4'h1,
		C_STEP        = 4'h2,
		C_STEP_U      = 4'h3,
		C_STEP_IN     = 4'h4,
		C_STEP_IN_U   = 4'h5,
		C_STEP_OUT    = 4'h6,
		C_STEP_OUT_U  = 4'h7,
		C_READ        = 4'h8,
		C_READ_M      = 4'h9,
		C_WRITE       = 4'hA,
		C_WRITE_M     = 4'hB,
		C_READ_ADDR   = 4'hC,
		C_FORCE_INT   = 4'hD,
		C_READ_TRACK  = 4'hE,
		C_WRITE_TRACK = 4'hF
	} cmd_group_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_SEARCH,
		S_READ_DELAY,
		S_READ_WAIT,
		S_ABORT,
		S_BUSY_WAIT,
		S_END_CMD
	} engine_state_t;

endpackage

// ==== verilog/fdc_disk_pkg.sv ====
`include "fdc_settings.svh"

package fdc_disk_pkg;

	typedef logic [7:0] track_t;
	typedef logic [7:0] sector_t;   // 1-based as on the media

	// sector size is 128 << size code
	typedef logic [1:0] size_code_t;

	// 0: 26x128  1: 16x256  2: 9x512  3: 5x1024  4: 10x512
	typedef logic [2:0] geometry_t;

	typedef logic [10:0] byte_ofs_t;   // up to 1024 bytes per sector

	typedef logic [`FDC_IMAGE_AW-1:0] image_addr_t;

endpackage

// ==== verilog/fdc_host_if.sv ====
`timescale 1ns/10ps

interface fdc_host_if;

	logic                   cmd_strobe;    // rising edge of a write
	fdc_bus_pkg::reg_addr_t reg_addr;      // latched at strobe start
	fdc_bus_pkg::byte_t     wdata;
	logic                   data_taken;    // host finished reading data reg
	logic                   status_taken;  // host finished reading status
	logic                   data_given;    // host finished writing data reg

	modport bus (
		output cmd_strobe,
		output reg_addr,
		output wdata,
		output data_taken,
		output status_taken,
		output data_given
	);

	modport engine (
		input cmd_strobe,
		input reg_addr,
		input wdata,
		input data_taken,
		input status_taken,
		input data_given
	);

endinterface

// ==== verilog/fdc_host_bus.sv ====
`timescale 1ns/10ps

module fdc_host_bus (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               io_en,
	input  logic               rd,
	input  logic               wr,
	input  logic [1:0]         addr,
	input  fdc_bus_pkg::byte_t din,
	input  fdc_bus_pkg::byte_t status,
	input  fdc_bus_pkg::byte_t track_reg,
	input  fdc_bus_pkg::byte_t sector_reg,
	input  fdc_bus_pkg::byte_t data_reg,
	input  logic               buff_byte_sel,
	input  fdc_bus_pkg::byte_t buff_din,
	output fdc_bus_pkg::byte_t dout,
	fdc_host_if.bus            host
);

	logic rd_en;
	logic wr_en;
	logic old_rd;
	logic old_wr;

	assign rd_en = rd & io_en;
	assign wr_en = wr & io_en;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_rd            <= 1'b0;
			old_wr            <= 1'b0;
			host.cmd_strobe   <= 1'b0;
			host.data_taken   <= 1'b0;
			host.status_taken <= 1'b0;
			host.data_given   <= 1'b0;
		end else begin
			old_rd <= rd_en;
			old_wr <= wr_en;
			host.cmd_strobe <= wr_en & ~old_wr;
			// end of strobe events use the address seen at its start
			host.data_taken   <= old_rd & ~rd_en & (host.reg_addr == fdc_bus_pkg::A_DATA);
			host.status_taken <= old_rd & ~rd_en & (host.reg_addr == fdc_bus_pkg::A_CMD_STATUS);
			host.data_given   <= old_wr & ~wr_en & (host.reg_addr == fdc_bus_pkg::A_DATA);
		end
	end

	always_ff @(posedge clk_sys) begin
		if ((rd_en & ~old_rd) | (wr_en & ~old_wr))
			host.reg_addr <= fdc_bus_pkg::reg_addr_t'(addr);
		if (wr_en & ~old_wr)
			host.wdata <= din;
	end

	// read mux follows the live address
	always_comb begin
		case (fdc_bus_pkg::reg_addr_t'(addr))
			fdc_bus_pkg::A_CMD_STATUS: dout = status;
			fdc_bus_pkg::A_TRACK:      dout = track_reg;
			fdc_bus_pkg::A_SECTOR:     dout = sector_reg;
			default:                   dout = buff_byte_sel ? buff_din : data_reg;
		endcase
	end

endmodule

// ==== verilog/fdc_sector_map.sv ====
`timescale 1ns/10ps

module fdc_sector_map (
	input  fdc_disk_pkg::geometry_t   geometry,
	input  fdc_disk_pkg::track_t      track,
	input  logic                      side,
	input  fdc_disk_pkg::sector_t     sector,
	output fdc_disk_pkg::image_addr_t sector_base,
	output fdc_disk_pkg::sector_t     sectors_per_track,
	output fdc_disk_pkg::size_code_t  size_code
);

	fdc_disk_pkg::image_addr_t phys_track;
	fdc_disk_pkg::image_addr_t lba;

	always_comb begin
		case (geometry)
			3'd1: begin
				sectors_per_track = 8'd16;
				size_code         = 2'd1;
			end
			3'd2: begin
				sectors_per_track = 8'd9;
				size_code         = 2'd2;
			end
			3'd3: begin
				sectors_per_track = 8'd5;
				size_code         = 2'd3;
			end
			3'd4: begin
				sectors_per_track = 8'd10;
				size_code         = 2'd2;
			end
			default: begin   // 0 and the unused codes
				sectors_per_track = 8'd26;
				size_code         = 2'd0;
			end
		endcase
	end

	// track-side-sector order, both sides of a track are adjacent
	assign phys_track  = fdc_disk_pkg::image_addr_t'({track, side});
	assign lba         = phys_track * fdc_disk_pkg::image_addr_t'(sectors_per_track)
	                   + fdc_disk_pkg::image_addr_t'(sector) - 1'b1;
	assign sector_base = (lba << 7) << size_code;

endmodule

// ==== verilog/fdc_drive_timing.sv ====
`timescale 1ns/10ps
`include "fdc_settings.svh"

module fdc_drive_timing (
	input  logic clk_sys,
	input  logic reset,
	input  logic ready,
	input  logic watchdog_set,
	output logic index,
	output logic watchdog_bark
);

	localparam logic [`FDC_INDEX_W-1:0] INDEX_RELOAD = `FDC_INDEX_PERIOD - 1;
	localparam logic [`FDC_INDEX_W-1:0] INDEX_START  = `FDC_INDEX_PERIOD - `FDC_INDEX_WIDTH;
	localparam logic [`FDC_WATCHDOG_W-1:0] WD_RELOAD = `FDC_WATCHDOG_CYCLES;

	logic [`FDC_INDEX_W-1:0]    index_cnt;
	logic [`FDC_WATCHDOG_W-1:0] wd_cnt;

	// =====================================================================
	// index hole, one revolution per period
	// =====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset || !ready || index_cnt == '0)
			index_cnt <= INDEX_RELOAD;   // parked at the top while not ready
		else
			index_cnt <= index_cnt - 1'b1;
	end

	assign index = ready && (index_cnt >= INDEX_START);

	// lost data watchdog, held at reload while set
	always_ff @(posedge clk_sys) begin
		if (reset)
			wd_cnt <= '0;
		else if (watchdog_set)
			wd_cnt <= WD_RELOAD;
		else if (wd_cnt != '0)
			wd_cnt <= wd_cnt - 1'b1;
	end

	assign watchdog_bark = (wd_cnt == '0);

endmodule

// ==== verilog/fdc_command_engine.sv ====
`timescale 1ns/10ps
`include "fdc_settings.svh"

module fdc_command_engine (
	input  logic                      clk_sys,
	input  logic                      reset,
	fdc_host_if.engine                host,
	input  logic                      ready,
	input  logic                      wp,
	input  logic                      side,
	input  logic                      index,
	input  logic                      watchdog_bark,
	input  fdc_disk_pkg::image_addr_t sector_base,
	input  fdc_disk_pkg::sector_t     sectors_per_track,
	input  fdc_disk_pkg::size_code_t  size_code,
	output logic                      watchdog_set,
	output fdc_bus_pkg::byte_t        track_reg,
	output fdc_bus_pkg::byte_t        sector_reg,
	output fdc_bus_pkg::byte_t        data_reg,
	output fdc_disk_pkg::track_t      disk_track,
	output fdc_bus_pkg::byte_t        status,
	output logic                      buff_byte_sel,
	output fdc_disk_pkg::byte_ofs_t   byte_offset,
	output logic                      drq,
	output logic                      busy,
	output logic                      intrq
);

	localparam logic [`FDC_TIMER_W-1:0] SEEK_RELOAD = `FDC_SEEK_CYCLES;
	localparam logic [`FDC_TIMER_W-1:0] BUSY_RELOAD = `FDC_BUSY_CYCLES;
	localparam logic [`FDC_TIMER_W-1:0] BYTE_RELOAD = `FDC_BYTE_DELAY;
	localparam logic IMAGE_READ_ONLY = 1'b1;

	fdc_bus_pkg::engine_state_t state;
	fdc_bus_pkg::cmd_group_t    cmd;
	logic [`FDC_TIMER_W-1:0]    timer;
	logic [10:0]                sector_size;
	logic [`FDC_IMAGE_AW:0]     sector_end;
	fdc_disk_pkg::track_t       next_track;
	logic step_dir;      // 1 steps out towards track 0
	logic multi;
	logic multi_run;     // searching a follow-on sector
	logic side_bad;
	logic sector_bad;
	logic last_byte;
	logic cmd_mode;
	logic head_loaded;
	logic seek_err;
	logic lost_data;
	logic wr_fault;
	logic protect;

	assign cmd         = fdc_bus_pkg::cmd_group_t'(host.wdata[7:4]);
	assign sector_size = 11'd128 << size_code;
	assign last_byte   = (byte_offset == sector_size - 11'd1);
	assign sector_end  = {1'b0, sector_base} + {{(`FDC_IMAGE_AW-10){1'b0}}, sector_size};
	assign next_track  = (host.wdata[6] ? host.wdata[5] : step_dir) ? disk_track - 8'd1
	                                                              : disk_track + 8'd1;
	assign sector_bad  = (sector_reg == 8'd0) || (sector_reg > sectors_per_track) || side_bad
	                   || (sector_end > {1'b1, {`FDC_IMAGE_AW{1'b0}}});   // past image end

	// =====================================================================
	// status register, mode picked by the last command
	// =====================================================================
	assign protect = IMAGE_READ_ONLY | wp;
	assign status  = cmd_mode ?
		{~ready, protect, wr_fault, seek_err | ~ready, 1'b0, lost_data, drq, busy} :
		{~ready, protect, head_loaded, seek_err | ~ready, 1'b0, disk_track == 8'd0, index, busy};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= fdc_bus_pkg::S_IDLE;
			timer         <= '0;
			track_reg     <= '0;
			sector_reg    <= '0;
			data_reg      <= '0;
			disk_track    <= '0;
			byte_offset   <= '0;
			step_dir      <= 1'b0;
			multi         <= 1'b0;
			multi_run     <= 1'b0;
			side_bad      <= 1'b0;
			cmd_mode      <= 1'b0;
			head_loaded   <= 1'b0;
			seek_err      <= 1'b0;
			lost_data     <= 1'b0;
			wr_fault      <= 1'b0;
			buff_byte_sel <= 1'b0;
			watchdog_set  <= 1'b0;
			drq           <= 1'b0;
			busy          <= 1'b0;
			intrq         <= 1'b0;
		end else begin
			if (host.status_taken)
				intrq <= 1'b0;

			case (state)
				fdc_bus_pkg::S_SEARCH: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state    <= fdc_bus_pkg::S_END_CMD;
					end else if (timer != '0) begin
						timer <= timer - 1'b1;
					end else if (sector_bad) begin
						seek_err <= !multi_run;   // running off the track end is normal
						state    <= fdc_bus_pkg::S_END_CMD;
					end else begin
						byte_offset <= '0;
						timer       <= BYTE_RELOAD;
						state       <= fdc_bus_pkg::S_READ_DELAY;
					end
				end
				fdc_bus_pkg::S_READ_DELAY: begin
					if (timer != '0) begin
						timer        <= timer - 1'b1;
						watchdog_set <= 1'b1;
					end else begin
						watchdog_set <= 1'b0;   // watchdog starts with drq
						drq          <= 1'b1;
						state        <= fdc_bus_pkg::S_READ_WAIT;
					end
				end
				fdc_bus_pkg::S_READ_WAIT: begin
					if (host.data_taken || watchdog_bark) begin
						drq <= 1'b0;
						if (!host.data_taken)
							lost_data <= 1'b1;   // byte skipped
						if (!last_byte) begin
							byte_offset <= byte_offset + 1'b1;
							timer       <= BYTE_RELOAD;
							state       <= fdc_bus_pkg::S_READ_DELAY;
						end else if (multi) begin
							sector_reg <= sector_reg + 8'd1;
							multi_run  <= 1'b1;
							timer      <= SEEK_RELOAD;
							state      <= fdc_bus_pkg::S_SEARCH;
						end else begin
							state <= fdc_bus_pkg::S_END_CMD;
						end
					end
				end
				fdc_bus_pkg::S_ABORT: begin
					seek_err  <= 1'b0;
					lost_data <= 1'b0;
					wr_fault  <= 1'b0;
					state     <= fdc_bus_pkg::S_END_CMD;
				end
				fdc_bus_pkg::S_BUSY_WAIT: begin
					if (timer != '0)
						timer <= timer - 1'b1;
					else
						state <= fdc_bus_pkg::S_END_CMD;
				end
				fdc_bus_pkg::S_END_CMD: begin
					busy          <= 1'b0;
					drq           <= 1'b0;
					watchdog_set  <= 1'b0;
					buff_byte_sel <= 1'b0;
					intrq         <= 1'b1;
					state         <= fdc_bus_pkg::S_IDLE;
				end
				default: ;
			endcase

			// =============================================================
			// host register writes, these override the FSM above
			// =============================================================
			if (host.cmd_strobe) begin
				case (host.reg_addr)
					fdc_bus_pkg::A_CMD_STATUS: begin
						intrq <= 1'b0;
						if (cmd == fdc_bus_pkg::C_FORCE_INT) begin
							cmd_mode <= 1'b0;
							if (state != fdc_bus_pkg::S_IDLE) begin
								state <= fdc_bus_pkg::S_ABORT;
							end else begin
								seek_err  <= 1'b0;
								lost_data <= 1'b0;
								wr_fault  <= 1'b0;
								drq       <= 1'b0;
								busy      <= 1'b0;
							end
						end else if (state == fdc_bus_pkg::S_IDLE
						             && cmd != fdc_bus_pkg::C_READ_ADDR) begin
							// default path is a plain busy period
							cmd_mode  <= host.wdata[7];
							busy      <= 1'b1;
							seek_err  <= 1'b0;
							lost_data <= 1'b0;
							wr_fault  <= 1'b0;
							timer     <= BUSY_RELOAD;
							state     <= fdc_bus_pkg::S_BUSY_WAIT;
							if (!host.wdata[7])
								head_loaded <= host.wdata[3];   // type I h flag
							case (cmd)
								fdc_bus_pkg::C_RESTORE: begin
									track_reg  <= '0;
									disk_track <= '0;
								end
								fdc_bus_pkg::C_SEEK: begin
									track_reg  <= data_reg;
									disk_track <= data_reg;
								end
								fdc_bus_pkg::C_STEP, fdc_bus_pkg::C_STEP_U,
								fdc_bus_pkg::C_STEP_IN, fdc_bus_pkg::C_STEP_IN_U,
								fdc_bus_pkg::C_STEP_OUT, fdc_bus_pkg::C_STEP_OUT_U: begin
									if (host.wdata[6])
										step_dir <= host.wdata[5];   // remembered for plain step
									disk_track <= next_track;
									if (host.wdata[4])
										track_reg <= next_track;
								end
								fdc_bus_pkg::C_READ, fdc_bus_pkg::C_READ_M: begin
									buff_byte_sel <= 1'b1;
									multi         <= host.wdata[4];
									multi_run     <= 1'b0;
									side_bad      <= host.wdata[1] && (host.wdata[3] != side);
									timer         <= SEEK_RELOAD;
									state         <= fdc_bus_pkg::S_SEARCH;
								end
								fdc_bus_pkg::C_WRITE, fdc_bus_pkg::C_WRITE_M,
								fdc_bus_pkg::C_WRITE_TRACK:
									wr_fault <= 1'b1;   // image cannot be written
								fdc_bus_pkg::C_READ_TRACK:
									seek_err <= 1'b1;
								default: ;
							endcase
						end
					end
					fdc_bus_pkg::A_TRACK:
						if (!busy)
							track_reg <= host.wdata;
					fdc_bus_pkg::A_SECTOR:
						if (!busy)
							sector_reg <= host.wdata;
					default: ;   // data reg loads at end of strobe
				endcase
			end

			if (host.data_given)
				data_reg <= host.wdata;
		end
	end

endmodule

// ==== verilog/fdc_controller.sv ====
`timescale 1ns/10ps
`include "fdc_settings.svh"

module fdc_controller (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     io_en,
	input  logic                     rd,
	input  logic                     wr,
	input  logic [1:0]               addr,
	input  fdc_bus_pkg::byte_t       din,
	output fdc_bus_pkg::byte_t       dout,
	output logic                     drq,
	output logic                     intrq,
	output logic                     busy,
	input  logic                     wp,
	input  logic                     ready,
	input  logic                     side,
	input  fdc_disk_pkg::geometry_t  size_code,
	output logic [`FDC_IMAGE_AW-1:0] buff_addr,
	output logic                     buff_read,
	input  fdc_bus_pkg::byte_t       buff_din
);

	fdc_bus_pkg::byte_t        status;
	fdc_bus_pkg::byte_t        track_reg;
	fdc_bus_pkg::byte_t        sector_reg;
	fdc_bus_pkg::byte_t        data_reg;
	logic                      buff_byte_sel;
	fdc_disk_pkg::track_t      disk_track;
	fdc_disk_pkg::image_addr_t sector_base;
	fdc_disk_pkg::sector_t     sectors_per_track;
	fdc_disk_pkg::size_code_t  sector_size_code;
	fdc_disk_pkg::byte_ofs_t   byte_offset;
	logic                      watchdog_set;
	logic                      watchdog_bark;
	logic                      index;

	fdc_host_if host_if ();

	fdc_host_bus host_bus_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.io_en         (io_en),
		.rd            (rd),
		.wr            (wr),
		.addr          (addr),
		.din           (din),
		.status        (status),
		.track_reg     (track_reg),
		.sector_reg    (sector_reg),
		.data_reg      (data_reg),
		.buff_byte_sel (buff_byte_sel),
		.buff_din      (buff_din),
		.dout          (dout),
		.host          (host_if.bus)
	);

	fdc_sector_map sector_map_i (
		.geometry          (size_code),
		.track             (disk_track),
		.side              (side),
		.sector            (sector_reg),
		.sector_base       (sector_base),
		.sectors_per_track (sectors_per_track),
		.size_code         (sector_size_code)
	);

	fdc_drive_timing drive_timing_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ready         (ready),
		.watchdog_set  (watchdog_set),
		.index         (index),
		.watchdog_bark (watchdog_bark)
	);

	fdc_command_engine command_engine_i (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.host              (host_if.engine),
		.ready             (ready),
		.wp                (wp),
		.side              (side),
		.index             (index),
		.watchdog_bark     (watchdog_bark),
		.sector_base       (sector_base),
		.sectors_per_track (sectors_per_track),
		.size_code         (sector_size_code),
		.watchdog_set      (watchdog_set),
		.track_reg         (track_reg),
		.sector_reg        (sector_reg),
		.data_reg          (data_reg),
		.disk_track        (disk_track),
		.status            (status),
		.buff_byte_sel     (buff_byte_sel),
		.byte_offset       (byte_offset),
		.drq               (drq),
		.busy              (busy),
		.intrq             (intrq)
	);

	// image RAM answers combinationally
	assign buff_addr = sector_base + fdc_disk_pkg::image_addr_t'(byte_offset);
	assign buff_read = buff_byte_sel && (addr == fdc_bus_pkg::A_DATA);

endmodule

// ==== test/fdc_controller_properties.sv ====
`timescale 1ns/10ps
`include "fdc_settings.svh"

module fdc_controller_properties (
	input logic                       clk_sys,
	input logic                       reset,
	input logic                       drq,
	input logic                       busy,
	input logic                       intrq,
	input logic                       index,
	input fdc_bus_pkg::engine_state_t state
);

	int fail_count = 0;   // read by the testbench at the end

	// a byte is only offered while a command runs
	drq_needs_busy: assert property (@(posedge clk_sys) disable iff (reset) drq |-> busy)
		else begin
			fail_count++;
			$error("drq high while busy is low");
		end

	// drq lives in the wait state, or on the way out of an abort
	drq_in_transfer: assert property (@(posedge clk_sys) disable iff (reset)
		drq |-> state inside {fdc_bus_pkg::S_READ_WAIT, fdc_bus_pkg::S_ABORT,
		                      fdc_bus_pkg::S_END_CMD})
		else begin
			fail_count++;
			$error("drq high outside a sector transfer");
		end

	intrq_apart_from_drq: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(intrq) |-> !$rose(drq))
		else begin
			fail_count++;
			$error("intrq and drq rose in the same cycle");
		end

	// =========================================================================
	// index pulse length
	// =========================================================================
	index_width: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(index) |=> ##[0:`FDC_INDEX_WIDTH-1] !index)
		else begin
			fail_count++;
			$error("index pulse longer than its width");
		end

endmodule

bind fdc_controller fdc_controller_properties properties_i (
	.clk_sys (clk_sys),
	.reset   (reset),
	.drq     (drq),
	.busy    (busy),
	.intrq   (intrq),
	.index   (index),
	.state   (command_engine_i.state)
);

// ==== test/fdc_controller_tb.sv ====
`timescale 1ns/10ps
`include "fdc_settings.svh"

module fdc_controller_tb;

	localparam int K_PLAIN = 0;
	localparam int K_LOST  = 1;   // some bytes left past the watchdog
	localparam int K_ABORT = 2;   // force interrupt after the first drq
	localparam int DRQ_TIMEOUT   = `FDC_BUSY_CYCLES;
	localparam int LOST_TIMEOUT  = `FDC_WATCHDOG_CYCLES + 50;
	localparam int INTRQ_TIMEOUT = 2 * `FDC_BUSY_CYCLES;

	typedef struct {
		string                    name;
		fdc_disk_pkg::geometry_t  geom;
		fdc_disk_pkg::track_t     track;
		logic                     side;
		fdc_disk_pkg::sector_t    sector;
		fdc_bus_pkg::cmd_group_t  cmd;
		int                       nbytes;
		int                       kind;
		fdc_bus_pkg::byte_t       status;
		fdc_bus_pkg::byte_t       mask;
	} row_t;

	logic                      clk_sys = 1'b0;
	logic                      reset;
	logic                      io_en;
	logic                      rd;
	logic                      wr;
	logic [1:0]                addr;
	fdc_bus_pkg::byte_t        din;
	fdc_bus_pkg::byte_t        dout;
	logic                      drq;
	logic                      intrq;
	logic                      busy;
	logic                      wp;
	logic                      ready;
	logic                      side;
	fdc_disk_pkg::geometry_t   size_code;
	fdc_disk_pkg::image_addr_t buff_addr;
	logic                      buff_read;
	fdc_bus_pkg::byte_t        buff_din;
	integer                    seed;
	row_t                      rows [0:11];
	fdc_bus_pkg::byte_t        value;
	logic                      ram_read;   // image RAM side seen during the last read
	fdc_disk_pkg::image_addr_t ram_addr;

	always #20 clk_sys = ~clk_sys;

	fdc_controller fdc_controller_i (.*);

	// image RAM content depends on every address bit
	function automatic fdc_bus_pkg::byte_t image_byte(input fdc_disk_pkg::image_addr_t a);
		return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
	endfunction

	assign buff_din = image_byte(buff_addr);

	function automatic int track_sectors(input int geom);
		case (geom)
			1: return 16;
			2: return 9;
			3: return 5;
			4: return 10;
			default: return 26;
		endcase
	endfunction

	function automatic int sector_bytes(input int geom);
		case (geom)
			1: return 256;
			2: return 512;
			3: return 1024;
			4: return 512;
			default: return 128;
		endcase
	endfunction

	// track-side-sector layout with sectors counted from 1
	function automatic int expected_addr(input int geom, input int track, input int sd,
	                                     input int sector, input int ofs);
		return ((track * 2 + sd) * track_sectors(geom) + sector - 1) * sector_bytes(geom) + ofs;
	endfunction

	// =========================================================================
	// error handling and checks
	// =========================================================================
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (actual !== expected)
			fail_stop($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h",
			                    name, expected, actual));
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// =========================================================================
	// host bus cycles
	// =========================================================================
	task automatic write_reg(input logic [1:0] a, input fdc_bus_pkg::byte_t data);
		@(posedge clk_sys);
		addr  <= a;
		din   <= data;
		io_en <= 1'b1;
		wr    <= 1'b1;
		@(posedge clk_sys);
		wr    <= 1'b0;   // cmd_strobe shows up now
		io_en <= 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] a, output fdc_bus_pkg::byte_t data);
		@(posedge clk_sys);
		addr  <= a;
		io_en <= 1'b1;
		rd    <= 1'b1;
		@(negedge clk_sys);
		data     = dout;
		ram_read = buff_read;
		ram_addr = buff_addr;
		@(posedge clk_sys);
		rd    <= 1'b0;
		io_en <= 1'b0;
		repeat (2) @(posedge clk_sys);   // taken pulse reaches the engine
	endtask

	task automatic wait_drq(input string name);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!drq) begin
			if (n == DRQ_TIMEOUT)
				fail_stop({"timeout waiting for drq in ", name});
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_drq_low(input string name);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (drq) begin
			if (n == LOST_TIMEOUT)
				fail_stop({"drq was never withdrawn by the watchdog in ", name});
			n++;
			@(negedge clk_sys);
		end
	endtask

	task automatic wait_intrq(input string name, input bit no_drq, output int cycles);
		cycles = 0;
		@(negedge clk_sys);
		while (!intrq) begin
			if (no_drq && drq)
				fail_stop({"drq raised where no data was expected in ", name});
			if (cycles == INTRQ_TIMEOUT)
				fail_stop({"timeout waiting for intrq in ", name});
			cycles++;
			@(negedge clk_sys);
		end
	endtask

	task automatic type1_command(input string name, input fdc_bus_pkg::byte_t command,
	                             input fdc_bus_pkg::byte_t track);
		fdc_bus_pkg::byte_t data;
		int                 cycles;
		write_reg(fdc_bus_pkg::A_CMD_STATUS, command);
		wait_intrq(name, 1'b1, cycles);
		check({name, " busy time"}, `FDC_BUSY_CYCLES + 3, cycles);   // +1 to busy, +2 end
		check({name, " busy"}, 0, busy);
		read_reg(fdc_bus_pkg::A_CMD_STATUS, data);
		@(negedge clk_sys);
		check({name, " intrq after status"}, 0, intrq);
		read_reg(fdc_bus_pkg::A_TRACK, data);
		check({name, " track"}, track, data);
	endtask

	task automatic apply_row(input row_t r);
		fdc_bus_pkg::byte_t data;
		int                 cycles;
		int                 size;
		int                 off;
		int                 lost_pick;
		int                 exp_addr;
		bit                 delayed;
		size      = sector_bytes(r.geom);
		lost_pick = $random(seed) & 127;
		@(posedge clk_sys);
		size_code <= r.geom;
		side      <= r.side;
		// head to the track first
		write_reg(fdc_bus_pkg::A_DATA, r.track);
		idle(3);
		write_reg(fdc_bus_pkg::A_CMD_STATUS, {fdc_bus_pkg::C_SEEK, 4'h0});
		wait_intrq({r.name, " seek"}, 1'b1, cycles);
		read_reg(fdc_bus_pkg::A_CMD_STATUS, data);
		write_reg(fdc_bus_pkg::A_SECTOR, r.sector);
		idle(3);
		write_reg(fdc_bus_pkg::A_CMD_STATUS, {r.cmd, 4'h0});
		if (r.kind == K_ABORT) begin
			wait_drq(r.name);
			write_reg(fdc_bus_pkg::A_CMD_STATUS, {fdc_bus_pkg::C_FORCE_INT, 4'h0});
		end
		for (off = 0; off < r.nbytes; off++) begin
			wait_drq(r.name);
			delayed = (r.kind == K_LOST) && ((off == lost_pick) || (($random(seed) & 31) == 0));
			if (delayed) begin
				wait_drq_low(r.name);   // byte skipped
			end else begin
				exp_addr = expected_addr(r.geom, r.track, r.side,
				                         r.sector + off / size, off % size);
				read_reg(fdc_bus_pkg::A_DATA, data);
				check($sformatf("%s buff_read %0d", r.name, off), 1, ram_read);
				check($sformatf("%s address %0d", r.name, off), exp_addr, ram_addr);
				check($sformatf("%s byte %0d", r.name, off),
				      image_byte(fdc_disk_pkg::image_addr_t'(exp_addr)), data);
			end
		end
		wait_intrq(r.name, r.kind != K_ABORT, cycles);
		check({r.name, " busy"}, 0, busy);
		check({r.name, " drq"}, 0, drq);
		read_reg(fdc_bus_pkg::A_CMD_STATUS, data);
		check({r.name, " status"}, r.status, data & r.mask);
	endtask

	initial begin
		reset     = 1'b1;
		io_en     = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		addr      = 2'd0;
		din       = 8'h00;
		wp        = 1'b0;
		ready     = 1'b1;
		side      = 1'b0;
		size_code = 3'd0;
		seed      = 5732;
		rows = '{
			'{"read g0", 3'd0, 8'd3, 1'b0, 8'd1, fdc_bus_pkg::C_READ, 128, K_PLAIN,
			  8'h40, 8'hFF},
			'{"read g1", 3'd1, 8'd10, 1'b1, 8'd16, fdc_bus_pkg::C_READ, 256, K_PLAIN,
			  8'h40, 8'hFF},
			'{"read g2", 3'd2, 8'd39, 1'b1, 8'd5, fdc_bus_pkg::C_READ, 512, K_PLAIN,
			  8'h40, 8'hFF},
			'{"read g3", 3'd3, 8'd79, 1'b0, 8'd3, fdc_bus_pkg::C_READ, 1024, K_PLAIN,
			  8'h40, 8'hFF},
			'{"read g4", 3'd4, 8'd20, 1'b1, 8'd10, fdc_bus_pkg::C_READ, 512, K_PLAIN,
			  8'h40, 8'hFF},
			'{"sector zero", 3'd2, 8'd1, 1'b0, 8'd0, fdc_bus_pkg::C_READ, 0, K_PLAIN,
			  8'h50, 8'hFF},
			'{"sector beyond", 3'd1, 8'd2, 1'b0, 8'd17, fdc_bus_pkg::C_READ, 0, K_PLAIN,
			  8'h50, 8'hFF},
			'{"read track", 3'd0, 8'd0, 1'b0, 8'd1, fdc_bus_pkg::C_READ_TRACK, 0, K_PLAIN,
			  8'h50, 8'hFF},
			'{"write sector", 3'd0, 8'd5, 1'b0, 8'd1, fdc_bus_pkg::C_WRITE, 0, K_PLAIN,
			  8'h60, 8'hFF},
			'{"lost data", 3'd0, 8'd7, 1'b1, 8'd4, fdc_bus_pkg::C_READ, 128, K_LOST,
			  8'h44, 8'hFF},
			'{"force int", 3'd1, 8'd4, 1'b0, 8'd2, fdc_bus_pkg::C_READ, 0, K_ABORT,
			  8'h40, 8'hF1},
			'{"multi read", 3'd0, 8'd12, 1'b0, 8'd1, fdc_bus_pkg::C_READ_M, 26 * 128,
			  K_PLAIN, 8'h40, 8'hFF}
		};
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		idle(2);

		// free running index bit masked off
		read_reg(fdc_bus_pkg::A_CMD_STATUS, value);
		check("reset status", 8'h44, value & 8'hFD);
		write_reg(fdc_bus_pkg::A_TRACK, 8'h2A);
		idle(3);
		read_reg(fdc_bus_pkg::A_TRACK, value);
		check("track readback", 8'h2A, value);
		write_reg(fdc_bus_pkg::A_SECTOR, 8'h07);
		idle(3);
		read_reg(fdc_bus_pkg::A_SECTOR, value);
		check("sector readback", 8'h07, value);

		type1_command("restore", {fdc_bus_pkg::C_RESTORE, 4'h0}, 8'd0);
		write_reg(fdc_bus_pkg::A_DATA, 8'd10);
		idle(3);
		read_reg(fdc_bus_pkg::A_DATA, value);
		check("data readback", 8'd10, value);
		check("buff_read while idle", 0, ram_read);
		type1_command("seek", {fdc_bus_pkg::C_SEEK, 4'h0}, 8'd10);
		type1_command("step in", {fdc_bus_pkg::C_STEP_IN_U, 4'h0}, 8'd11);
		type1_command("step out", {fdc_bus_pkg::C_STEP_OUT_U, 4'h0}, 8'd10);

		foreach (rows[i])
			apply_row(rows[i]);
		idle(4);

		if (fdc_controller_i.properties_i.fail_count != 0) begin
			fail_stop("concurrent assertions failed during the run");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== fdc_controller.f ====
+incdir+verilog
verilog/fdc_bus_pkg.sv
verilog/fdc_disk_pkg.sv
verilog/fdc_host_if.sv
verilog/fdc_host_bus.sv
verilog/fdc_sector_map.sv
verilog/fdc_drive_timing.sv
verilog/fdc_command_engine.sv
verilog/fdc_controller.sv
test/fdc_controller_properties.sv
test/fdc_controller_tb.sv
